// File: alu_if.sv
`timescale 1ns/10ps
`default_nettype none

interface alu_if
    import cpu_pkg::*;
();

    alu_op_e op;
    data_t   opa;
    data_t   opb;
    logic    carry_in;

    // Returned in the same cycle
    data_t   result;
    flags_t  flags_out;

    modport seq (output op, opa, opb, carry_in, input  result, flags_out);
    modport alu (input  op, opa, opb, carry_in, output result, flags_out);

endinterface

`default_nettype wire

// File: build.f
+incdir+.
cpu_pkg.sv
reg_wr_if.sv
alu_if.sv
cpu_alu.sv
cpu_regfile.sv
cpu_sequencer.sv
cpu_top.sv
tb_cpu_top.sv

// File: cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    alu_if.alu alu
);

    // Bit DATA_W is carry for adds and borrow for subtracts
    logic [DATA_W:0] wide;

    // ------------------------------
    // Arithmetic and logic
    // ------------------------------
    always_comb begin
        wide = '0;
        case (alu.op)
            ALU_ADD: wide = {1'b0, alu.opa} + {1'b0, alu.opb};
            ALU_ADC: begin
                wide = {1'b0, alu.opa} + {1'b0, alu.opb} + {{DATA_W{1'b0}}, alu.carry_in};
            end
            ALU_SUB,
            ALU_CP:  wide = {1'b0, alu.opa} - {1'b0, alu.opb};
            ALU_SBC: begin
                wide = {1'b0, alu.opa} - {1'b0, alu.opb} - {{DATA_W{1'b0}}, alu.carry_in};
            end
            // Logic ops leave carry clear
            ALU_AND: wide = {1'b0, alu.opa & alu.opb};
            ALU_XOR: wide = {1'b0, alu.opa ^ alu.opb};
            ALU_OR:  wide = {1'b0, alu.opa | alu.opb};
            default: wide = '0;
        endcase
    end

    assign alu.result = wide[DATA_W-1:0];

    // ------------------------------
    // Flags
    // ------------------------------
    always_comb begin
        alu.flags_out.sign   = wide[DATA_W-1];
        alu.flags_out.zero   = (wide[DATA_W-1:0] == '0);
        alu.flags_out.parity = ~^wide[DATA_W-1:0];
        alu.flags_out.carry  = wide[DATA_W];
    end

    // The op comes straight from the opcode field, so an X here means
    // the sequencer decoded garbage
    always_comb begin
        assert final (!$isunknown(alu.op))
            else $error("ALU operation is unknown");
    end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Register codes as they appear in the opcode fields
    typedef logic [2:0] reg_sel_t;
    typedef logic [1:0] pair_sel_t;

    localparam reg_sel_t  REG_M   = 3'd6;
    localparam reg_sel_t  REG_A   = 3'd7;
    localparam pair_sel_t PAIR_HL = 2'd2;

    // Parity is set on an even number of ones
    typedef struct packed {
        logic sign;
        logic zero;
        logic parity;
        logic carry;
    } flags_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP
    } alu_op_e;

    typedef enum logic [2:0] {
        COND_NZ, COND_Z, COND_NC, COND_C,
        COND_PO, COND_PE, COND_P, COND_M
    } cond_e;

    typedef enum logic [1:0] {
        PH_FETCH, PH_ARG1, PH_ARG2, PH_HALT
    } phase_e;

    localparam addr_t RESET_PC = 16'h0000;

endpackage

`default_nettype wire

// File: cpu_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_regfile
    import cpu_pkg::*;
(
    input  logic     pin_clk,
    input  logic     pin_rstn,
    input  reg_sel_t rd_sel_i,
    output data_t    rd_data_o,
    output data_t    a_o,
    output addr_t    hl_o,
    reg_wr_if.rf     wr
);

    // Indexed by register code, slot 6 (M) is never written and reads as zero
    data_t regs [0:7];

    always_ff @(posedge pin_clk) begin
        if (!pin_rstn) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we16) begin
            // Pair n is high byte 2n and low byte 2n+1, SP code dropped
            if (wr.sel16 <= PAIR_HL) begin
                regs[{wr.sel16, 1'b0}] <= wr.wdata_hi;
                regs[{wr.sel16, 1'b1}] <= wr.wdata_lo;
            end
        end else if (wr.we8) begin
            if (wr.sel8 != REG_M) begin
                regs[wr.sel8] <= wr.wdata_lo;
            end
        end
    end

    // Read ports
    assign rd_data_o = regs[rd_sel_i];
    assign a_o       = regs[REG_A];
    assign hl_o      = {regs[{PAIR_HL, 1'b0}], regs[{PAIR_HL, 1'b1}]};

    // Sequencer must keep the write strobes exclusive and never target M
    assert property (@(posedge pin_clk) disable iff (!pin_rstn)
        !(wr.we8 && wr.we16) && !(wr.we8 && (wr.sel8 == REG_M)))
        else $error("illegal register write request");

endmodule

`default_nettype wire

// File: cpu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic     pin_clk,
    input  logic     pin_rstn,
    input  data_t    mem_rdata_i,
    output addr_t    mem_addr_o,
    output data_t    mem_wdata_o,
    output data_t    io_addr_o,
    output data_t    io_wdata_o,
    output logic     mem_we_o,
    output logic     io_we_o,
    output logic     halt_o,
    output reg_sel_t rd_sel_o,
    input  data_t    rd_data_i,
    input  data_t    a_i,
    input  addr_t    hl_i,
    reg_wr_if.seq    wr,
    alu_if.seq       alu
);

    addr_t    pc;
    data_t    ir;
    data_t    imm_lo;
    flags_t   flags_q;
    phase_e   phase;
    phase_e   phase_nxt;
    data_t    io_addr_q;
    data_t    io_wdata_q;
    logic     io_we_q;

    data_t    opcode;
    reg_sel_t dst_sel;
    reg_sel_t src_sel;
    alu_op_e  alu_op;
    cond_e    cond;
    logic     is_ld_rp_nn, is_ld_r_n, is_halt, is_ld_r_m, is_ld_m_r, is_ld_r_r;
    logic     is_alu_r, is_alu_n, is_alu, is_jp, is_out;
    logic     multi_cycle;
    logic     cond_ok;
    logic     jp_take;
    logic     use_hl;

    // ------------------------------
    // Decode
    // ------------------------------
    // Fetch decodes the bus byte directly, later phases use the latch
    assign opcode  = (phase == PH_FETCH) ? mem_rdata_i : ir;
    assign dst_sel = reg_sel_t'(opcode[5:3]);
    assign src_sel = reg_sel_t'(opcode[2:0]);
    assign alu_op  = alu_op_e'(opcode[5:3]);
    assign cond    = cond_e'(opcode[5:3]);

    assign is_ld_rp_nn = (opcode[7:6] == 2'b00) && (opcode[3:0] == 4'b0001)
                         && (opcode[5:4] != 2'b11);
    assign is_ld_r_n   = (opcode[7:6] == 2'b00) && (src_sel == 3'b110) && (dst_sel != REG_M);
    assign is_halt     = (opcode == 8'h76);
    assign is_ld_r_m   = (opcode[7:6] == 2'b01) && (src_sel == REG_M) && (dst_sel != REG_M);
    assign is_ld_m_r   = (opcode[7:6] == 2'b01) && (dst_sel == REG_M) && (src_sel != REG_M);
    assign is_ld_r_r   = (opcode[7:6] == 2'b01) && (dst_sel != REG_M) && (src_sel != REG_M);
    assign is_alu_r    = (opcode[7:6] == 2'b10);
    assign is_alu_n    = (opcode[7:6] == 2'b11) && (src_sel == 3'b110);
    assign is_alu      = is_alu_r || is_alu_n;
    assign is_jp       = (opcode == 8'hC3) || ((opcode[7:6] == 2'b11) && (src_sel == 3'b010));
    assign is_out      = (opcode == 8'hD3);

    assign multi_cycle = is_ld_rp_nn || is_ld_r_n || is_ld_r_m || is_ld_m_r
                         || is_alu || is_jp || is_out;

    // Jump condition from the stored flags
    always_comb begin
        case (cond)
            COND_NZ: cond_ok = !flags_q.zero;
            COND_Z:  cond_ok =  flags_q.zero;
            COND_NC: cond_ok = !flags_q.carry;
            COND_C:  cond_ok =  flags_q.carry;
            COND_PO: cond_ok = !flags_q.parity;
            COND_PE: cond_ok =  flags_q.parity;
            COND_P:  cond_ok = !flags_q.sign;
            default: cond_ok =  flags_q.sign;
        endcase
    end

    assign jp_take = (opcode == 8'hC3) || cond_ok;

    // ------------------------------
    // Bus and ALU operands
    // ------------------------------
    assign use_hl = (phase == PH_ARG1)
                    && (is_ld_r_m || is_ld_m_r || (is_alu_r && (src_sel == REG_M)));

    assign mem_addr_o  = use_hl ? hl_i : pc;
    assign mem_wdata_o = rd_data_i;
    assign mem_we_o    = (phase == PH_ARG1) && is_ld_m_r;
    assign rd_sel_o    = src_sel;

    assign io_addr_o  = io_addr_q;
    assign io_wdata_o = io_wdata_q;
    assign io_we_o    = io_we_q;
    assign halt_o     = (phase == PH_HALT);

    assign alu.op       = alu_op;
    assign alu.opa      = a_i;
    assign alu.opb      = (is_alu_n || (src_sel == REG_M)) ? mem_rdata_i : rd_data_i;
    assign alu.carry_in = flags_q.carry;

    // ------------------------------
    // Register write port
    // ------------------------------
    always_comb begin
        wr.we8      = 1'b0;
        wr.we16     = 1'b0;
        wr.sel8     = dst_sel;
        wr.sel16    = pair_sel_t'(opcode[5:4]);
        wr.wdata_hi = mem_rdata_i;
        wr.wdata_lo = mem_rdata_i;
        case (phase)
            PH_FETCH: begin
                if (is_ld_r_r) begin
                    wr.we8      = 1'b1;
                    wr.wdata_lo = rd_data_i;
                end
            end
            PH_ARG1: begin
                if (is_ld_r_n || is_ld_r_m) begin
                    wr.we8 = 1'b1;
                end else if (is_alu && (alu_op != ALU_CP)) begin
                    wr.we8      = 1'b1;
                    wr.sel8     = REG_A;
                    wr.wdata_lo = alu.result;
                end
            end
            PH_ARG2: begin
                // High byte is on the bus now, low byte was latched
                if (is_ld_rp_nn) begin
                    wr.we16     = 1'b1;
                    wr.wdata_lo = imm_lo;
                end
            end
            default: ;
        endcase
    end

    // ------------------------------
    // Phase FSM and PC
    // ------------------------------
    always_comb begin
        phase_nxt = PH_FETCH;
        case (phase)
            PH_FETCH: begin
                if (is_halt) begin
                    phase_nxt = PH_HALT;
                end else if (multi_cycle) begin
                    phase_nxt = PH_ARG1;
                end
            end
            PH_ARG1: begin
                if (is_ld_rp_nn || is_jp) begin
                    phase_nxt = PH_ARG2;
                end
            end
            PH_HALT: phase_nxt = PH_HALT;
            default: phase_nxt = PH_FETCH;
        endcase
    end

    always_ff @(posedge pin_clk) begin
        if (!pin_rstn) begin
            pc      <= RESET_PC;
            ir      <= '0;
            phase   <= PH_FETCH;
            flags_q <= '0;
            io_we_q <= 1'b0;
        end else begin
            phase   <= phase_nxt;
            io_we_q <= 1'b0;
            case (phase)
                PH_FETCH: begin
                    ir <= mem_rdata_i;
                    // PC stays on the HALT opcode
                    if (!is_halt) begin
                        pc <= pc + 1'b1;
                    end
                end
                PH_ARG1: begin
                    if (is_ld_rp_nn || is_jp || is_ld_r_n || is_alu_n || is_out) begin
                        pc <= pc + 1'b1;
                    end
                    if (is_alu) begin
                        flags_q <= alu.flags_out;
                    end
                    if (is_out) begin
                        io_we_q <= 1'b1;
                    end
                end
                PH_ARG2: begin
                    if (is_jp && jp_take) begin
                        pc <= {mem_rdata_i, imm_lo};
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Immediate low byte and port payload
    always_ff @(posedge pin_clk) begin
        if (phase == PH_ARG1) begin
            imm_lo <= mem_rdata_i;
            if (is_out) begin
                io_addr_q  <= mem_rdata_i;
                io_wdata_q <= a_i;
            end
        end
    end

    // Opcode is never stored during a write cycle
    assert property (@(posedge pin_clk) disable iff (!pin_rstn)
        !(mem_we_o && (phase == PH_FETCH)))
        else $error("memory write during fetch");

    // Only reset leaves the halt state
    assert property (@(posedge pin_clk) disable iff (!pin_rstn)
        halt_o |=> halt_o)
        else $error("halt dropped without reset");

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic  pin_clk,
    input  logic  pin_rstn,
    input  data_t mem_rdata_i,
    output addr_t mem_addr_o,
    output data_t mem_wdata_o,
    output logic  mem_we_o,
    output data_t io_addr_o,
    output data_t io_wdata_o,
    output logic  io_we_o,
    output logic  halt_o
);

    reg_sel_t rd_sel;
    data_t    rd_data;
    data_t    a_val;
    addr_t    hl_val;

    reg_wr_if wr_bus ();
    alu_if    alu_bus ();

    cpu_sequencer u_seq (
        .pin_clk     (pin_clk),
        .pin_rstn    (pin_rstn),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .io_addr_o   (io_addr_o),
        .io_wdata_o  (io_wdata_o),
        .mem_we_o    (mem_we_o),
        .io_we_o     (io_we_o),
        .halt_o      (halt_o),
        .rd_sel_o    (rd_sel),
        .rd_data_i   (rd_data),
        .a_i         (a_val),
        .hl_i        (hl_val),
        .wr          (wr_bus),
        .alu         (alu_bus)
    );

    cpu_regfile u_rf (
        .pin_clk   (pin_clk),
        .pin_rstn  (pin_rstn),
        .rd_sel_i  (rd_sel),
        .rd_data_o (rd_data),
        .a_o       (a_val),
        .hl_o      (hl_val),
        .wr        (wr_bus)
    );

    cpu_alu u_alu (
        .alu (alu_bus)
    );

endmodule

`default_nettype wire

// File: reg_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface reg_wr_if
    import cpu_pkg::*;
();

    logic      we8;
    logic      we16;
    reg_sel_t  sel8;
    pair_sel_t sel16;
    data_t     wdata_hi;
    // Also the data for 8-bit writes
    data_t     wdata_lo;

    modport seq (output we8, we16, sel8, sel16, wdata_hi, wdata_lo);
    modport rf  (input  we8, we16, sel8, sel16, wdata_hi, wdata_lo);

endinterface

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile the CPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_cpu_top -o tb_cpu_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cpu_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

    // Opens a row whose data byte at DATA_ADDR is pre
    task automatic new_row(input data_t pre);
        prog_len[num_cases] = 0;
        ev_count[num_cases] = 0;
        preload[num_cases]  = pre;
        num_cases++;
    endtask

    // Appends n bytes with the most significant first
    task automatic put_bytes(input int n, input logic [63:0] v);
        int r;
        int i;
        r = num_cases - 1;
        for (i = n - 1; i >= 0; i--) begin
            prog[r][prog_len[r]] = v[8*i +: 8];
            prog_len[r]++;
        end
    endtask

    task automatic add_event(input ev_kind_e kind, input addr_t addr, input data_t data);
        int r;
        r = num_cases - 1;
        ev_kind[r][ev_count[r]] = kind;
        ev_addr[r][ev_count[r]] = addr;
        ev_data[r][ev_count[r]] = data;
        ev_count[r]++;
    endtask

    task automatic build_table();
        data_t   a;
        data_t   b;
        data_t   imm;
        data_t   opnd;
        data_t   res;
        data_t   pre;
        data_t   port;
        flags_t  f;
        logic    carry;
        alu_op_e op;
        cond_e   cc;
        addr_t   x;
        addr_t   y;
        addr_t   z;
        int      k;
        int      m;

        // Loads of HL and DE, LD r,n, LD r,r', stores and LD A,(HL) out to a port
        pre = data_t'($random(seed));
        new_row(pre);
        put_bytes(3, 24'h21_00_20);
        put_bytes(4, 32'h06_5A_48_71);
        put_bytes(2, 16'h2E_01);
        put_bytes(4, 32'h11_C3_99_73);
        put_bytes(3, 24'h2E_10_7E);
        put_bytes(3, 24'hD3_44_76);
        add_event(EV_MEM, 16'h2000, 8'h5A);
        add_event(EV_MEM, 16'h2001, 8'hC3);
        add_event(EV_IO, 16'h0044, pre);
        add_event(EV_HALT, 16'h0000, 8'h00);

        // BC pair, LD B,(HL) and a store of C back over the data byte
        pre = data_t'($random(seed));
        new_row(pre);
        put_bytes(6, 48'h01_78_56_21_10_20);
        put_bytes(4, 32'h46_78_D3_01);
        put_bytes(3, 24'h79_D3_02);
        put_bytes(2, 16'h71_76);
        add_event(EV_IO, 16'h0001, pre);
        add_event(EV_IO, 16'h0002, 8'h78);
        add_event(EV_MEM, DATA_ADDR, 8'h78);
        add_event(EV_HALT, 16'h0000, 8'h00);

        // Each ALU op on B, on (HL) and on an immediate with the carry kept between them
        for (k = 0; k < 8; k++) begin
            op    = alu_op_e'(k);
            a     = data_t'($random(seed));
            b     = data_t'($random(seed));
            pre   = data_t'($random(seed));
            imm   = data_t'($random(seed));
            carry = 1'b0;
            new_row(pre);
            put_bytes(3, 24'h21_10_20);
            put_bytes(2, {8'h06, b});
            for (m = 0; m < 3; m++) begin
                port = data_t'(8'h10 + m);
                put_bytes(2, {8'h3E, a});
                if (m == 0) begin
                    opnd = b;
                    put_bytes(1, {2'b10, op, 3'b000});
                end else if (m == 1) begin
                    opnd = pre;
                    put_bytes(1, {2'b10, op, 3'b110});
                end else begin
                    opnd = imm;
                    put_bytes(2, {2'b11, op, 3'b110, imm});
                end
                put_bytes(2, {8'hD3, port});
                alu_model(op, a, opnd, carry, res, f);
                carry = f.carry;
                add_event(EV_IO, {8'h00, port}, (op == ALU_CP) ? a : res);
            end
            put_bytes(1, 8'h76);
            add_event(EV_HALT, 16'h0000, 8'h00);
        end

        // 16-bit add through ADD then ADC with the low bytes forced to carry
        x = addr_t'($random(seed)) | 16'h0080;
        y = addr_t'($random(seed)) | 16'h0080;
        z = x + y;
        new_row(8'h00);
        put_bytes(6, {8'h3E, x[7:0], 8'hC6, y[7:0], 16'hD3_20});
        put_bytes(6, {8'h3E, x[15:8], 8'hCE, y[15:8], 16'hD3_21});
        put_bytes(1, 8'h76);
        add_event(EV_IO, 16'h0020, z[7:0]);
        add_event(EV_IO, 16'h0021, z[15:8]);
        add_event(EV_HALT, 16'h0000, 8'h00);

        // 16-bit subtract through SUB then SBC with the low bytes forced to borrow
        x = addr_t'($random(seed)) & 16'hFF7F;
        y = addr_t'($random(seed)) | 16'h0080;
        z = x - y;
        new_row(8'h00);
        put_bytes(6, {8'h3E, x[7:0], 8'hD6, y[7:0], 16'hD3_22});
        put_bytes(6, {8'h3E, x[15:8], 8'hDE, y[15:8], 16'hD3_23});
        put_bytes(1, 8'h76);
        add_event(EV_IO, 16'h0022, z[7:0]);
        add_event(EV_IO, 16'h0023, z[15:8]);
        add_event(EV_HALT, 16'h0000, 8'h00);

        // Every condition after two flag setups that differ in all four flags
        for (k = 0; k < 16; k++) begin
            cc = cond_e'(k / 2);
            a  = 8'h80;
            if (k % 2 == 0) begin
                op = ALU_ADD;
                b  = 8'h80;
            end else begin
                op = ALU_OR;
                b  = 8'h00;
            end
            alu_model(op, a, b, 1'b0, res, f);
            new_row(8'h00);
            put_bytes(4, {8'h3E, a, 2'b11, op, 3'b110, b});
            // JP cc to 000Ch with fall-through marker 11h and taken marker 22h
            put_bytes(3, {2'b11, cc, 3'b010, 16'h0C_00});
            put_bytes(5, 40'h3E_11_D3_30_76);
            put_bytes(5, 40'h3E_22_D3_30_76);
            add_event(EV_IO, 16'h0030, cond_holds(cc, f) ? 8'h22 : 8'h11);
            add_event(EV_HALT, 16'h0000, 8'h00);
        end

        // NOP, a dropped opcode (CPL) as NOP, and code after HALT that must never run
        new_row(8'h00);
        put_bytes(4, 32'h00_3E_9C_2F);
        put_bytes(3, 24'hD3_07_76);
        put_bytes(3, 24'hD3_08_76);
        add_event(EV_IO, 16'h0007, 8'h9C);
        add_event(EV_HALT, 16'h0000, 8'h00);
    endtask

`endif

// File: tb_cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int    MAX_CASES    = 32;
    localparam int    PROG_LEN     = 24;
    localparam int    MAX_EVENTS   = 8;
    localparam int    MEM_SIZE     = 65536;
    localparam int    CLK_HALF     = 4;
    localparam int    RESET_CYCLES = 10;
    localparam int    HALT_WATCH   = 20;
    localparam addr_t DATA_ADDR    = 16'h2010;

    typedef enum logic [1:0] {
        EV_MEM, EV_IO, EV_HALT
    } ev_kind_e;

    logic  pin_clk;
    logic  pin_rstn;
    data_t mem_rdata;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_we;
    data_t io_addr;
    data_t io_wdata;
    logic  io_we;
    logic  halt;

    data_t mem [0:MEM_SIZE-1];

    // Test table with one row per program
    data_t    prog     [MAX_CASES][PROG_LEN];
    int       prog_len [MAX_CASES];
    data_t    preload  [MAX_CASES];
    ev_kind_e ev_kind  [MAX_CASES][MAX_EVENTS];
    addr_t    ev_addr  [MAX_CASES][MAX_EVENTS];
    data_t    ev_data  [MAX_CASES][MAX_EVENTS];
    int       ev_count [MAX_CASES];
    int       num_cases;

    int       cur_case;
    int       ev_idx;
    integer   seed;
    int       cycles;
    int       cycle_limit;

    cpu_top dut_i (
        .pin_clk     (pin_clk),
        .pin_rstn    (pin_rstn),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_we_o    (mem_we),
        .io_addr_o   (io_addr),
        .io_wdata_o  (io_wdata),
        .io_we_o     (io_we),
        .halt_o      (halt)
    );

    // ------------------------------
    // Memory, clock and timeout
    // ------------------------------
    assign mem_rdata = mem[mem_addr];

    always @(posedge pin_clk) begin
        if (mem_we === 1'b1) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    initial begin
        pin_clk = 1'b0;
        forever begin
            #CLK_HALF pin_clk = ~pin_clk;
        end
    end

    always @(posedge pin_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("Timeout: no result after %0d clock cycles", cycle_limit));
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopped at the first failure");
    endtask

    // ------------------------------
    // Reference rules
    // ------------------------------
    // Result and flags as the instruction set defines them
    function automatic void alu_model(input alu_op_e op, input data_t a, input data_t b,
                                      input logic cin, output data_t res, output flags_t f);
        int ia;
        int ib;
        int ic;
        int t;
        int ones;
        ia = a;
        ib = b;
        ic = cin;
        case (op)
            ALU_ADD:         t = ia + ib;
            ALU_ADC:         t = ia + ib + ic;
            ALU_SUB, ALU_CP: t = ia - ib;
            ALU_SBC:         t = ia - ib - ic;
            ALU_AND:         t = ia & ib;
            ALU_XOR:         t = ia ^ ib;
            default:         t = ia | ib;
        endcase
        res = data_t'(t);
        // Out of range means carry for adds and borrow for subtracts
        f.carry = (t < 0) || (t > 255);
        f.sign  = res[7];
        f.zero  = (res == 8'h00);
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += res[i];
        end
        f.parity = (ones % 2 == 0);
    endfunction

    function automatic bit cond_holds(input cond_e cc, input flags_t f);
        case (cc)
            COND_NZ: return !f.zero;
            COND_Z:  return f.zero;
            COND_NC: return !f.carry;
            COND_C:  return f.carry;
            COND_PO: return !f.parity;
            COND_PE: return f.parity;
            COND_P:  return !f.sign;
            default: return f.sign;
        endcase
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_mem_write(input addr_t addr, input data_t data);
        if (ev_idx >= ev_count[cur_case] || ev_kind[cur_case][ev_idx] != EV_MEM) begin
            stop_run($sformatf("Case %0d: memory write to %h was not expected as event %0d",
                cur_case, addr, ev_idx));
        end
        if (addr !== ev_addr[cur_case][ev_idx] || data !== ev_data[cur_case][ev_idx]) begin
            stop_run($sformatf("Error at %0t: case %0d mem[%h] = %h, expected mem[%h] = %h",
                $time, cur_case, addr, data, ev_addr[cur_case][ev_idx],
                ev_data[cur_case][ev_idx]));
        end
        ev_idx++;
    endtask

    task automatic check_io_write(input data_t port, input data_t value);
        if (ev_idx >= ev_count[cur_case] || ev_kind[cur_case][ev_idx] != EV_IO) begin
            stop_run($sformatf("Case %0d: port write to %h was not expected as event %0d",
                cur_case, port, ev_idx));
        end
        if ({8'h00, port} !== ev_addr[cur_case][ev_idx] || value !== ev_data[cur_case][ev_idx])
        begin
            stop_run($sformatf("Error at %0t: case %0d port %h = %h, expected port %h = %h",
                $time, cur_case, port, value, ev_addr[cur_case][ev_idx][7:0],
                ev_data[cur_case][ev_idx]));
        end
        ev_idx++;
    endtask

    task automatic check_halt();
        if (ev_idx != ev_count[cur_case] - 1 || ev_kind[cur_case][ev_idx] != EV_HALT) begin
            stop_run($sformatf("Case %0d: halted after %0d of %0d expected events",
                cur_case, ev_idx, ev_count[cur_case] - 1));
        end
        // Nothing may move on the buses while halted
        repeat (HALT_WATCH) begin
            @(negedge pin_clk);
            if (mem_we !== 1'b0 || io_we !== 1'b0 || halt !== 1'b1) begin
                stop_run($sformatf("Case %0d: bus activity or halt drop after HALT", cur_case));
            end
        end
    endtask

    task automatic run_case(input int idx);
        int i;
        bit halted;
        cur_case = idx;
        ev_idx   = 0;
        halted   = 1'b0;
        pin_rstn = 1'b0;
        for (i = 0; i < MEM_SIZE; i++) begin
            mem[i] <= 8'h00;
        end
        for (i = 0; i < prog_len[idx]; i++) begin
            mem[i] <= prog[idx][i];
        end
        mem[DATA_ADDR] <= preload[idx];
        repeat (RESET_CYCLES) @(negedge pin_clk);
        pin_rstn = 1'b1;
        while (!halted) begin
            @(negedge pin_clk);
            if (mem_we === 1'b1) begin
                check_mem_write(mem_addr, mem_wdata);
            end
            if (io_we === 1'b1) begin
                check_io_write(io_addr, io_wdata);
            end
            halted = (halt === 1'b1);
        end
        check_halt();
    endtask

    `include "tb_cases.svh"

    initial begin
        $timeformat(-9, 0, " ns", 0);
        pin_rstn    = 1'b0;
        seed        = 32'hb92b_c9d8;
        cycles      = 0;
        num_cases   = 0;
        cycle_limit = 0;
        build_table();
        for (int c = 0; c < num_cases; c++) begin
            cycle_limit += 4 * prog_len[c] + 30;
        end
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
